// ==== coinc_trigger.f ====
design/coinc_cfg_pkg.sv
design/coinc_event_pkg.sv
design/hit_sync.sv
design/hit_align_line.sv
design/coincidence_window.sv
design/trigger_sequencer.sv
design/coinc_trigger_top.sv
testbench/coinc_tb.sv

// ==== Bender.yml ====
package:
  name: coinc_trigger

sources:
  - files:
      - design/coinc_cfg_pkg.sv
      - design/coinc_event_pkg.sv
      - design/hit_sync.sv
      - design/hit_align_line.sv
      - design/coincidence_window.sv
      - design/trigger_sequencer.sv
      - design/coinc_trigger_top.sv
  - target: test
    files:
      - testbench/coinc_tb.sv

// ==== testbench/coinc_tb.sv ====
/*
 * coincidence trigger testbench: directed tests of line selection, group
 * logic, busy veto and prescaling, checked against a behavioral model
 */
`timescale 1ns/1ps

module coinc_tb;
	import coinc_cfg_pkg::*;
	import coinc_event_pkg::*;

	localparam int N_EVENTS    = 130;  // events over all tests, rounded up
	localparam int TIMEOUT_CYC = N_EVENTS * (2 + 255 + 255 + 10) + 2000;

	logic        clk_in, rst_in;
	hit_vec_t    hit_a_n, hit_b_n, hit_syn;
	busy_vec_t   busy_a_n, busy_b_n, busy_syn;
	coinc_cfg_t  cfg;
	logic        coincid_trg, si_busy, logic_match;
	grp_vec_t    coincid_tag;
	trg_counts_t counts;
	trg_counts_t exp_counts;  // model counters
	logic [31:0] lcg_state;
	int          mismatches, other_errs, trg_total, cycles;

	coinc_trigger_top dut0 (.*);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = ~clk_in;
	end

	// trigger level of the cycle that just ended, plus the run limit
	always @(posedge clk_in) begin
		cycles++;
		if (coincid_trg)
			trg_total++;
		if (cycles > TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, the test sequence never finished", cycles);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare_hits(input string what, input hit_vec_t got, input hit_vec_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_busy(input string what, input busy_vec_t got, input busy_vec_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_tag(input string what, input grp_vec_t got, input grp_vec_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s tag %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_counts(input string what, input trg_counts_t got,
			input trg_counts_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s counters %0d/%0d/%0d/%0d/%0d expected %0d/%0d/%0d/%0d/%0d",
				$time, what, got.mip1, got.mip2, got.gm1, got.gm2, got.ubs,
				exp.mip1, exp.mip2, exp.gm1, exp.gm2, exp.ubs);
		end
	endtask

	task automatic compare_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// group rules on one latched pattern, per selector code
	function automatic grp_vec_t expect_groups(input hit_vec_t h);
		grp_vec_t std_res, r;
		logic     cal13;
		int       g;
		cal13 = h[CH_CAL1] | h[CH_CAL3];
		std_res[GRP_MIP1] = h[CH_ACD_TOP] & h[CH_ACD_SEC] & h[CH_CSI] & (h[CH_CAL2] | h[CH_CAL4]);
		std_res[GRP_MIP2] = h[CH_CAL2] & h[CH_CAL4];
		std_res[GRP_GM1]  = !h[CH_ACD_TOP] & !h[CH_ACD_SEC] & h[CH_CSI] & cal13;
		std_res[GRP_GM2]  = !(h[CH_ACD_TOP] & h[CH_ACD_SEC]) & h[CH_CSI] & cal13;
		std_res[GRP_UBS]  = cal13;
		for (g = 0; g < N_GRP; g++)
			r[g] = (cfg.grp_sel[g] == 2'd1) & std_res[g];
		if (cfg.grp_sel[GRP_MIP1] == 2'd0)
			r[GRP_MIP1] = h[CH_ACD_TOP] & h[CH_CSI];  // timing check mode
		return r;
	endfunction

	function automatic int ratio(input div_code_t code, input logic ubs);
		int mip_tab [8] = '{1, 2, 4, 32, 64, 128, 256, 512};
		int ubs_tab [8] = '{1, 32, 64, 128, 256, 512, 1024, 2048};
		return ubs ? ubs_tab[code] : mip_tab[code];
	endfunction

	// one verdict through the model, counters move on every result
	task automatic predict(input hit_vec_t seed_pat, input busy_vec_t busy,
			output grp_vec_t tag, inout int trgs);
		grp_vec_t res, en;
		res          = expect_groups(seed_pat);
		en           = '1;
		en[GRP_MIP1] = (exp_counts.mip1 % ratio(cfg.mip1_div, 1'b0)) == 0;
		en[GRP_MIP2] = (exp_counts.mip2 % ratio(cfg.mip2_div, 1'b0)) == 0;
		en[GRP_UBS]  = (exp_counts.ubs % ratio(cfg.ubs_div, 1'b1)) == 0;
		tag = res & en;
		if (|(tag & cfg.grp_oe) && (cfg.burst_en || (busy & ~cfg.busy_mask) == '0))
			trgs++;
		exp_counts.mip1 += res[GRP_MIP1];
		exp_counts.mip2 += res[GRP_MIP2];
		exp_counts.gm1  += res[GRP_GM1];
		exp_counts.gm2  += res[GRP_GM2];
		exp_counts.ubs  += res[GRP_UBS];
	endtask

	function automatic int max_delay();
		int c, d, m;
		m = 0;
		for (c = 0; c < N_HIT; c++) begin
			d = cfg.align[c];
			if (c == CH_ACD_TOP || c == CH_ACD_SEC || c == CH_ACD_SID)
				d += cfg.acd_csi_diff;
			if (d > m)
				m = d;
		end
		return m;
	endfunction

	// selected copy carries the pattern, the other copy is noise
	task automatic drive_lines(input hit_vec_t hits, input busy_vec_t busy);
		logic [31:0] r;
		int          c;
		r = lcg_next();
		for (c = 0; c < N_HIT; c++) begin
			hit_a_n[c] = cfg.hit_ab_sel[c] ? r[31-c] : ~hits[c];
			hit_b_n[c] = cfg.hit_ab_sel[c] ? ~hits[c] : r[31-c];
		end
		for (c = 0; c < N_BUSY; c++) begin
			busy_a_n[c] = cfg.busy_ab_sel[c] ? r[20+c] : ~busy[c];
			busy_b_n[c] = cfg.busy_ab_sel[c] ? ~busy[c] : r[20+c];
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk_in);
			drive_lines('0, '0);
		end
	endtask

	task automatic apply_reset();
		rst_in = 1'b1;
		repeat (5) @(posedge clk_in);
		@(negedge clk_in);
		rst_in     = 1'b0;
		exp_counts = '0;
	endtask

	// acd lines pulse first, the rest lead cycles later
	task automatic drive_event(input hit_vec_t pat, input busy_vec_t busy, input int lead,
			input int width, output int trgs, output logic lm);
		int       bound, cyc, start;
		logic     fired;
		hit_vec_t acd, act;
		acd             = '0;
		acd[CH_ACD_TOP] = pat[CH_ACD_TOP];
		acd[CH_ACD_SEC] = pat[CH_ACD_SEC];
		acd[CH_ACD_SID] = pat[CH_ACD_SID];
		bound = lead + width + 2 + max_delay() + cfg.seed_win + 3 + 4;  // pin to trigger
		start = trg_total;
		fired = 1'b0;
		lm    = 1'b0;
		cyc   = 0;
		while (cyc < bound && !(fired && cyc > lead + width)) begin
			act = '0;
			if (cyc < width)
				act |= acd;
			if (cyc >= lead && cyc < lead + width)
				act |= pat & ~acd;
			drive_lines(act, busy);
			@(negedge clk_in);
			fired |= coincid_trg;
			lm    |= logic_match;
			cyc++;
		end
		idle(max_delay() + width + 4);  // window drains and re-arms
		trgs = trg_total - start;
		if (trgs > 1) begin
			other_errs++;
			$display("pattern %h raised %0d triggers instead of at most one", pat, trgs);
		end
	endtask

	task automatic run_event(input string what, input hit_vec_t pat, input busy_vec_t busy,
			input int lead);
		grp_vec_t tag;
		int       exp_trgs, trgs;
		logic     lm;
		exp_trgs = 0;
		predict(pat, busy, tag, exp_trgs);
		drive_event(pat, busy, lead, 3, trgs, lm);
		compare_tag(what, coincid_tag, tag);
		compare_bit({what, " trigger"}, trgs != 0, exp_trgs != 0);
		compare_bit({what, " logic_match"}, lm, |(expect_groups(pat) & cfg.grp_oe));
		compare_counts(what, counts, exp_counts);
	endtask

	task automatic set_defaults();
		logic [31:0] r;
		r = lcg_next();
		cfg              = '0;
		cfg.hit_ab_sel   = r[31:24];
		cfg.busy_ab_sel  = r[23:22];
		cfg.acd_csi_diff = 8'd6;  // acd leads csi by six clocks
		cfg.align        = {N_HIT{4'd1}};
		cfg.seed_win     = 8'd4;
		cfg.grp_sel      = {N_GRP{SEL_STD}};
		cfg.grp_oe       = '1;
	endtask

	task automatic test_reset();
		int n;
		for (n = 0; n < 2; n++) begin
			compare_hits("reset hit_syn", hit_syn, '0);
			compare_busy("reset busy_syn", busy_syn, '0);
			compare_tag("reset", coincid_tag, '0);
			compare_counts("reset", counts, '0);
			compare_bit("reset trigger", coincid_trg, 1'b0);
			compare_bit("reset logic_match", logic_match, 1'b0);
			compare_bit("reset si_busy", si_busy, 1'b0);
			idle(20);
		end
		compare_bit("trigger while idle", trg_total != 0, 1'b0);
	endtask

	task automatic test_selection();
		hit_vec_t    exp_h;
		busy_vec_t   exp_b;
		logic [31:0] r;
		int          i, c, trgs;
		logic        lm;
		cfg.grp_sel = {N_GRP{2'd3}};  // hits flow but no group fires
		for (i = 0; i < 24; i++) begin
			r = lcg_next();
			cfg.hit_ab_sel  = r[31:24];
			cfg.hit_mask    = r[23:16];
			cfg.busy_ab_sel = r[15:14];
			cfg.busy_mask   = r[13:12];
			r = lcg_next();
			hit_a_n  = r[31:24];
			hit_b_n  = r[23:16];
			busy_a_n = r[15:14];
			busy_b_n = r[13:12];
			for (c = 0; c < N_HIT; c++)
				exp_h[c] = !cfg.hit_mask[c] && !(cfg.hit_ab_sel[c] ? hit_b_n[c] : hit_a_n[c]);
			for (c = 0; c < N_BUSY; c++)
				exp_b[c] = !cfg.busy_mask[c] && !(cfg.busy_ab_sel[c] ? busy_b_n[c] : busy_a_n[c]);
			repeat (2) @(posedge clk_in);
			@(negedge clk_in);
			compare_hits("selected hits", hit_syn, exp_h);
			compare_busy("selected busy", busy_syn, exp_b);
			compare_bit("si_busy", si_busy, |exp_b);
		end
		idle(max_delay() + cfg.seed_win + 12);  // last random window closes
		set_defaults();
		cfg.hit_mask = '1;
		drive_event('1, '0, 0, 4, trgs, lm);
		compare_bit("all masked trigger", trgs != 0, 1'b0);
		compare_bit("all masked logic_match", lm, 1'b0);
		compare_counts("all masked", counts, exp_counts);
		cfg.hit_mask = '0;
	endtask

	task automatic test_groups();
		hit_vec_t pats [8] = '{8'hD4, 8'hD0, 8'h90, 8'h05, 8'h18, 8'h92, 8'hD8, 8'h24};
		hit_vec_t p;
		int       code, i;
		for (code = 0; code < 4; code++) begin
			cfg.grp_sel = {N_GRP{grp_sel_t'(code)}};
			for (i = 0; i < 12; i++) begin
				p = (i < 8) ? pats[i] : hit_vec_t'(lcg_next() >> 24);
				if (p == '0)
					p = 8'h08;  // an empty pattern opens no window
				run_event($sformatf("code %0d pattern %h", code, p), p, '0, cfg.acd_csi_diff);
			end
		end
		set_defaults();
	endtask

	// acd lead not compensated, csi lands after the window closed
	task automatic test_skew();
		grp_vec_t tag;
		int       exp_trgs, trgs;
		logic     lm;
		cfg.grp_sel[GRP_MIP1] = 2'd0;
		cfg.acd_csi_diff      = 8'd0;
		cfg.seed_win          = 8'd2;
		exp_trgs = 0;
		predict(8'h80, '0, tag, exp_trgs);  // top alone
		predict(8'h10, '0, tag, exp_trgs);  // csi in a window of its own
		drive_event(8'h90, '0, 6, 2, trgs, lm);
		compare_tag("skewed", coincid_tag, tag);
		compare_bit("skewed trigger", trgs != 0, exp_trgs != 0);
		compare_bit("skewed logic_match", lm, 1'b0);  // top and csi never share a seed
		compare_counts("skewed", counts, exp_counts);
		set_defaults();
	endtask

	task automatic test_busy();
		run_event("mip2 under busy", 8'h05, 2'b01, 0);
		cfg.burst_en = 1'b1;
		run_event("mip2 in burst mode", 8'h05, 2'b10, 0);
		cfg.burst_en         = 1'b0;
		cfg.grp_oe[GRP_MIP2] = 1'b0;
		run_event("mip2 output disabled", 8'h05, '0, 0);
		set_defaults();
	endtask

	task automatic test_prescale();
		trg_counts_t total;
		int          i;
		apply_reset();  // counters from zero
		cfg.mip1_div = 3'd1;
		for (i = 0; i < 8; i++)
			run_event($sformatf("mip1 event %0d", i + 1), 8'hD4, '0, cfg.acd_csi_diff);
		cfg.ubs_div = 3'd1;
		for (i = 0; i < 40; i++)
			run_event($sformatf("ubs event %0d", i + 1), 8'h08, '0, 0);
		// every event counted whatever the prescale
		total      = '0;
		total.mip1 = CNT_W'(8);
		total.ubs  = CNT_W'(40);
		compare_counts("final", counts, total);
	endtask

	initial begin
		lcg_state  = 32'h70f9fbd5;
		exp_counts = '0;
		set_defaults();
		hit_a_n  = '1;
		hit_b_n  = '1;
		busy_a_n = '1;
		busy_b_n = '1;
		apply_reset();
		test_reset();
		test_selection();
		test_groups();
		test_skew();
		test_busy();
		test_prescale();
		$display("mismatches %0d, other errors %0d", mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== design/coinc_trigger_top.sv ====
/*
 * coincidence trigger top: front end sync, eight delay lines,
 * the seed window and the trigger sequencer
 */
`timescale 1ns/1ps

module coinc_trigger_top (
	input  logic                         clk_in,
	input  logic                         rst_in,
	input  coinc_event_pkg::hit_vec_t    hit_a_n,
	input  coinc_event_pkg::hit_vec_t    hit_b_n,
	input  coinc_event_pkg::busy_vec_t   busy_a_n,
	input  coinc_event_pkg::busy_vec_t   busy_b_n,
	input  coinc_cfg_pkg::coinc_cfg_t    cfg,
	output logic                         coincid_trg,
	output coinc_event_pkg::grp_vec_t    coincid_tag,
	output coinc_event_pkg::trg_counts_t counts,
	output coinc_event_pkg::hit_vec_t    hit_syn,
	output coinc_event_pkg::busy_vec_t   busy_syn,
	output logic                         si_busy,
	output logic                         logic_match
);
	import coinc_cfg_pkg::*;
	import coinc_event_pkg::*;

	align_req_t align_req [N_HIT];  // per channel hit and delay
	hit_vec_t   aligned;            // hits lined up on csi time
	verdict_t   verdict;

	hit_sync u_sync (
		.clk_in    (clk_in),
		.rst_in    (rst_in),
		.hit_a_n   (hit_a_n),
		.hit_b_n   (hit_b_n),
		.busy_a_n  (busy_a_n),
		.busy_b_n  (busy_b_n),
		.cfg       (cfg),
		.hit_syn   (hit_syn),
		.busy_syn  (busy_syn),
		.si_busy   (si_busy),
		.align_req (align_req)
	);

	for (genvar c = 0; c < N_HIT; c++) begin : g_align
		hit_align_line u_line (
			.clk_in  (clk_in),
			.rst_in  (rst_in),
			.req     (align_req[c]),
			.aligned (aligned[c])
		);
	end

	coincidence_window u_window (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.aligned     (aligned),
		.cfg         (cfg),
		.verdict     (verdict),
		.logic_match (logic_match)
	);

	trigger_sequencer u_seq (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.verdict     (verdict),
		.si_busy     (si_busy),  // veto input, raw synced busy
		.cfg         (cfg),
		.coincid_trg (coincid_trg),
		.coincid_tag (coincid_tag),
		.counts      (counts)
	);

endmodule

// ==== design/trigger_sequencer.sv ====
/*
 * trigger sequencer: prescales the groups, counts their events and
 * raises a one clock trigger with a tag of the groups that took part
 */
`timescale 1ns/1ps

module trigger_sequencer (
	input  logic                         clk_in,
	input  logic                         rst_in,
	input  coinc_event_pkg::verdict_t    verdict,
	input  logic                         si_busy,
	input  coinc_cfg_pkg::coinc_cfg_t    cfg,
	output logic                         coincid_trg,
	output coinc_event_pkg::grp_vec_t    coincid_tag,
	output coinc_event_pkg::trg_counts_t counts
);
	import coinc_cfg_pkg::*;
	import coinc_event_pkg::*;

	grp_vec_t en;    // prescale enables
	grp_vec_t fire;  // enabled groups with a result

	// low bits that must be zero for a 2**n prescale
	function automatic logic [CNT_W-1:0] low_mask(input logic [3:0] log2);
		return (CNT_W'(1) << log2) - CNT_W'(1);
	endfunction

	// enables look at the count before this event is added
	always_comb begin
		en           = '1;  // gamma groups never prescaled
		en[GRP_MIP1] = (counts.mip1 & low_mask(MIP_DIV_LOG2[cfg.mip1_div])) == '0;
		en[GRP_MIP2] = (counts.mip2 & low_mask(MIP_DIV_LOG2[cfg.mip2_div])) == '0;
		en[GRP_UBS]  = (counts.ubs & low_mask(UBS_DIV_LOG2[cfg.ubs_div])) == '0;
	end

	assign fire = en & verdict.result;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			coincid_trg <= 1'b0;
			coincid_tag <= '0;
		end else begin
			coincid_trg <= 1'b0;  // single clock pulse
			if (verdict.valid) begin
				coincid_tag <= fire;  // tagged even if vetoed below
				// burst mode runs through tracker busy
				coincid_trg <= |(fire & cfg.grp_oe) & (cfg.burst_en | ~si_busy);
			end
		end
	end

	// counters see every result, prescaled or not
	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			counts <= '0;
		end else if (verdict.valid) begin
			if (verdict.result[GRP_MIP1])
				counts.mip1 <= counts.mip1 + CNT_W'(1);
			if (verdict.result[GRP_MIP2])
				counts.mip2 <= counts.mip2 + CNT_W'(1);
			if (verdict.result[GRP_GM1])
				counts.gm1 <= counts.gm1 + CNT_W'(1);
			if (verdict.result[GRP_GM2])
				counts.gm2 <= counts.gm2 + CNT_W'(1);
			if (verdict.result[GRP_UBS])
				counts.ubs <= counts.ubs + CNT_W'(1);
		end
	end

	// fixed latency from window close to trigger
	a_trg_after_verdict: assert property (@(posedge clk_in) disable iff (rst_in)
		coincid_trg |-> $past(verdict.valid))
		else $error("trigger without a verdict one cycle earlier");

endmodule

// ==== design/coincidence_window.sv ====
/*
 * seed window: the first aligned hit opens a window, every channel
 * firing inside it is latched and the five coincidence groups are judged
 */
`timescale 1ns/1ps

module coincidence_window (
	input  logic                      clk_in,
	input  logic                      rst_in,
	input  coinc_event_pkg::hit_vec_t aligned,
	input  coinc_cfg_pkg::coinc_cfg_t cfg,
	output coinc_event_pkg::verdict_t verdict,
	output logic                      logic_match
);
	import coinc_cfg_pkg::*;
	import coinc_event_pkg::*;

	typedef enum logic [1:0] {
		IDLE,   // armed, waiting for a first hit
		SEED,   // window open, latching hits
		EVAL,   // seed complete, groups judged this cycle
		DRAIN   // wait for every line to drop
	} state_t;

	state_t             state;
	logic [DELAY_W-1:0] win_cnt;  // clocks of the window done after S
	hit_vec_t           seed;     // hits seen inside the window
	grp_vec_t           grp_next, grp_q;
	logic               valid_q;

	// seed bits by detector, sid takes part in no group
	logic top, sec, csi, cal1, cal2, cal3, cal4;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state   <= IDLE;
			win_cnt <= '0;
			seed    <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				IDLE: begin
					seed    <= aligned;  // zero while nothing fires
					win_cnt <= DELAY_W'(1);
					if (|aligned)  // cycle S
						state <= (cfg.seed_win == '0) ? EVAL : SEED;
				end
				SEED: begin
					seed <= seed | aligned;
					if (win_cnt == cfg.seed_win)  // last cycle S + seed_win
						state <= EVAL;
					else
						win_cnt <= win_cnt + DELAY_W'(1);
				end
				EVAL: begin
					valid_q <= 1'b1;  // grp_q takes the final seed on this edge
					state   <= DRAIN;
				end
				DRAIN: begin
					// seed held so logic_match stays up until re-arm
					if (aligned == '0)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign top  = seed[CH_ACD_TOP];
	assign sec  = seed[CH_ACD_SEC];
	assign csi  = seed[CH_CSI];
	assign cal1 = seed[CH_CAL1];
	assign cal2 = seed[CH_CAL2];
	assign cal3 = seed[CH_CAL3];
	assign cal4 = seed[CH_CAL4];

	// group logic, unsupported selector codes give no result
	always_comb begin
		grp_next = '0;
		case (cfg.grp_sel[GRP_MIP1])
			SEL_MIP1_TOPCSI: grp_next[GRP_MIP1] = top & csi;  // timing check mode
			SEL_STD:         grp_next[GRP_MIP1] = top & sec & csi & (cal2 | cal4);
			default:         grp_next[GRP_MIP1] = 1'b0;
		endcase
		if (cfg.grp_sel[GRP_MIP2] == SEL_STD)
			grp_next[GRP_MIP2] = cal2 & cal4;
		if (cfg.grp_sel[GRP_GM1] == SEL_STD)
			grp_next[GRP_GM1] = ~top & ~sec & csi & (cal1 | cal3);  // neutral, full veto
		if (cfg.grp_sel[GRP_GM2] == SEL_STD)
			grp_next[GRP_GM2] = (~top | ~sec) & csi & (cal1 | cal3);  // one acd may leak
		if (cfg.grp_sel[GRP_UBS] == SEL_STD)
			grp_next[GRP_UBS] = cal1 | cal3;  // unbiased, cal only
	end

	always_ff @(posedge clk_in) begin
		if (rst_in)
			grp_q <= '0;
		else
			grp_q <= grp_next;  // follows the seed every cycle
	end

	assign verdict     = '{valid: valid_q, result: grp_q};
	assign logic_match = |(grp_q & cfg.grp_oe);  // debug view, no T0 timing

	// one verdict per window, the sequencer counts each valid cycle
	a_verdict_single: assert property (@(posedge clk_in) disable iff (rst_in)
		verdict.valid |=> !verdict.valid)
		else $error("verdict valid held for two cycles");

endmodule

// ==== design/hit_align_line.sv ====
/*
 * one channel delay line, a ring of single bit entries read back
 * a programmable number of clocks after they were written
 */
`timescale 1ns/1ps

module hit_align_line (
	input  logic                       clk_in,
	input  logic                       rst_in,
	input  coinc_event_pkg::align_req_t req,
	output logic                       aligned
);
	import coinc_cfg_pkg::*;

	logic [RING_DEPTH-1:0] ring;    // hit history
	logic [DELAY_W-1:0]    wr_ptr;  // wraps on its own
	logic [DELAY_W-1:0]    rd_ptr;  // registered read address

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			ring   <= '0;  // nothing stale reaches the window
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			ring[wr_ptr] <= req.hit;
			wr_ptr       <= wr_ptr + DELAY_W'(1);
			// next cycle the write pointer has moved on by one, so the
			// read address lands exactly delay entries behind it
			rd_ptr       <= wr_ptr - req.delay + DELAY_W'(1);
		end
	end

	// hit written in cycle t shows here in cycle t + delay
	assign aligned = ring[rd_ptr];

endmodule

// ==== design/hit_sync.sv ====
/*
 * hit front end: picks the a or b copy of each line, masks it,
 * synchronizes it and works out the delay each channel needs
 */
`timescale 1ns/1ps

module hit_sync (
	input  logic                        clk_in,
	input  logic                        rst_in,
	input  coinc_event_pkg::hit_vec_t   hit_a_n,
	input  coinc_event_pkg::hit_vec_t   hit_b_n,
	input  coinc_event_pkg::busy_vec_t  busy_a_n,
	input  coinc_event_pkg::busy_vec_t  busy_b_n,
	input  coinc_cfg_pkg::coinc_cfg_t   cfg,
	output coinc_event_pkg::hit_vec_t   hit_syn,
	output coinc_event_pkg::busy_vec_t  busy_syn,
	output logic                        si_busy,
	output coinc_event_pkg::align_req_t align_req [coinc_cfg_pkg::N_HIT]
);
	import coinc_cfg_pkg::*;
	import coinc_event_pkg::*;

	hit_vec_t  hit_sel, hit_s1;   // selected lines, first sync stage
	busy_vec_t busy_sel, busy_s1;

	// pins are active low, ab_sel 0 takes copy a
	assign hit_sel  = ~cfg.hit_mask & ((~cfg.hit_ab_sel & ~hit_a_n) | (cfg.hit_ab_sel & ~hit_b_n));
	assign busy_sel = ~cfg.busy_mask &
		((~cfg.busy_ab_sel & ~busy_a_n) | (cfg.busy_ab_sel & ~busy_b_n));

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			hit_s1   <= '0;
			hit_syn  <= '0;
			busy_s1  <= '0;
			busy_syn <= '0;
		end else begin
			hit_s1   <= hit_sel;   // may go metastable
			hit_syn  <= hit_s1;
			busy_s1  <= busy_sel;
			busy_syn <= busy_s1;
		end
	end

	assign si_busy = |busy_syn;  // either tracker half busy

	// acd hits come early, they wait the acd to csi gap on top of their trim
	always_comb begin
		for (int c = 0; c < N_HIT; c++) begin
			align_req[c].hit   = hit_syn[c];
			align_req[c].delay = DELAY_W'(cfg.align[c]);
			if (c == CH_ACD_TOP || c == CH_ACD_SEC || c == CH_ACD_SID)
				align_req[c].delay = cfg.acd_csi_diff + DELAY_W'(cfg.align[c]);
		end
	end

	// a zero delay would read the ring a full turn late in the align line
	for (genvar c = 0; c < N_HIT; c++) begin : g_delay_chk
		a_delay_nonzero: assert property (@(posedge clk_in) disable iff (rst_in)
			align_req[c].delay != '0)
			else $error("channel %0d requests a zero align delay", c);
	end

endmodule

// ==== design/coinc_event_pkg.sv ====
/*
 * coincidence trigger event types: hit and busy vectors, per channel
 * delay requests, the window verdict and the group counters
 */
package coinc_event_pkg;

	localparam int CNT_W = 16;  // group event counter width

	typedef logic [coinc_cfg_pkg::N_HIT-1:0]  hit_vec_t;   // one bit per channel
	typedef logic [coinc_cfg_pkg::N_BUSY-1:0] busy_vec_t;
	typedef logic [coinc_cfg_pkg::N_GRP-1:0]  grp_vec_t;   // one bit per group

	// synchronized hit plus the delay it needs before the window
	typedef struct packed {
		logic                              hit;
		logic [coinc_cfg_pkg::DELAY_W-1:0] delay;  // 1..255 clocks
	} align_req_t;

	// single cycle result of one seed window, no ready side
	typedef struct packed {
		logic     valid;
		grp_vec_t result;
	} verdict_t;

	typedef struct packed {
		logic [CNT_W-1:0] mip1;
		logic [CNT_W-1:0] mip2;
		logic [CNT_W-1:0] gm1;
		logic [CNT_W-1:0] gm2;
		logic [CNT_W-1:0] ubs;
	} trg_counts_t;

endpackage

// ==== design/coinc_cfg_pkg.sv ====
/*
 * coincidence trigger configuration: widths, channel and group indices,
 * selector and prescale codes, and the register image seen by the trigger
 */
package coinc_cfg_pkg;

	localparam int N_HIT      = 8;             // hit channels
	localparam int N_BUSY     = 2;             // tracker busy lines
	localparam int N_GRP      = 5;             // coincidence groups
	localparam int DELAY_W    = 8;             // align delay width
	localparam int ALIGN_W    = 4;             // fine align per channel
	localparam int RING_DEPTH = 2 ** DELAY_W;  // delay ring entries

	// channel order on the hit vectors, msb first
	localparam int CH_ACD_TOP = 7;
	localparam int CH_ACD_SEC = 6;
	localparam int CH_ACD_SID = 5;
	localparam int CH_CSI     = 4;
	localparam int CH_CAL1    = 3;
	localparam int CH_CAL2    = 2;
	localparam int CH_CAL3    = 1;
	localparam int CH_CAL4    = 0;

	// group order on tag and result vectors
	localparam int GRP_MIP1 = 0;
	localparam int GRP_MIP2 = 1;
	localparam int GRP_GM1  = 2;
	localparam int GRP_GM2  = 3;
	localparam int GRP_UBS  = 4;

	typedef logic [1:0] grp_sel_t;
	localparam grp_sel_t SEL_MIP1_TOPCSI = 2'd0;  // top & csi, mip1 only
	localparam grp_sel_t SEL_STD         = 2'd1;  // standard group logic

	typedef logic [2:0] div_code_t;
	// prescale as log2 of the ratio, indexed by div code
	localparam logic [7:0][3:0] MIP_DIV_LOG2 = {4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd2, 4'd1, 4'd0};
	localparam logic [7:0][3:0] UBS_DIV_LOG2 = {4'd11, 4'd10, 4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd0};

	typedef struct packed {
		logic [N_HIT-1:0]              hit_ab_sel;   // 0 = copy a
		logic [N_HIT-1:0]              hit_mask;     // 1 = channel off
		logic [N_BUSY-1:0]             busy_ab_sel;
		logic [N_BUSY-1:0]             busy_mask;
		logic [DELAY_W-1:0]            acd_csi_diff; // acd lead over csi, in clocks
		logic [N_HIT-1:0][ALIGN_W-1:0] align;        // per channel trim
		logic [DELAY_W-1:0]            seed_win;     // seed window length
		grp_sel_t [N_GRP-1:0]          grp_sel;
		logic [N_GRP-1:0]              grp_oe;       // groups allowed to trigger
		div_code_t                     mip1_div;
		div_code_t                     mip2_div;
		div_code_t                     ubs_div;
		logic                          burst_en;     // ignore tracker busy
	} coinc_cfg_t;

endpackage
